/* design/wr_arb_pkg.sv */
`default_nettype none

package wr_arb_pkg;

    localparam int num_ch    = 5;
    localparam int ch_w      = 3;
    localparam int data_w    = 32;
    localparam int burst_len = 16;
    localparam int beat_w    = 4;
    localparam int rd_ptr_w  = 5;
    localparam int offset_w  = 16;
    localparam int addr_w    = ch_w + 1 + offset_w;

    // field view of one memory word address
    typedef struct packed {
        logic [ch_w-1:0]     ch;     // channel region
        logic                bank;   // ping-pong frame bank
        logic [offset_w-1:0] offset; // word offset in bank
    } mem_addr_fields_t;

    // flat word for the bus, fields for address building
    typedef union packed {
        logic [addr_w-1:0] word;
        mem_addr_fields_t  f;
    } mem_addr_u;

endpackage

`default_nettype wire

/* design/channel_scheduler.sv */
`default_nettype none

module channel_scheduler (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [wr_arb_pkg::num_ch-1:0]            ch_ready,
    input  logic                                     done,
    output logic                                     start,
    output logic [wr_arb_pkg::ch_w-1:0]              grant_ch
);

    import wr_arb_pkg::*;

    logic            busy;   // low while waiting on the current channel
    logic [ch_w-1:0] idx;

    assign grant_ch = idx;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (!busy) begin
                if (ch_ready[idx]) begin
                    start <= 1'b1; // one pulse per visit
                    busy  <= 1'b1;
                end
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // cyclic visit order that waits on a channel that is not ready
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx <= '0;
        end else if (busy && done) begin
            if (idx == ch_w'(num_ch - 1)) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/frame_addr_gen.sv */
`default_nettype none

module frame_addr_gen (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [wr_arb_pkg::ch_w-1:0]           grant_ch,
    input  logic                                  aw_fire,
    input  logic [wr_arb_pkg::num_ch-1:0]         ch_frame_end,
    output logic [wr_arb_pkg::addr_w-1:0]         burst_addr
);

    import wr_arb_pkg::*;

    logic [num_ch-1:0][offset_w-1:0] offset;
    logic [num_ch-1:0]               bank;
    mem_addr_u                       addr;

    always_comb begin
        addr.f.ch     = grant_ch;
        addr.f.bank   = bank[grant_ch];
        addr.f.offset = offset[grant_ch];
    end

    assign burst_addr = addr.word;

    // last burst of a frame moves the channel to its other bank
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            offset <= '0;
            bank   <= '0;
        end else if (aw_fire) begin
            if (ch_frame_end[grant_ch]) begin
                offset[grant_ch] <= '0;
                bank[grant_ch]   <= ~bank[grant_ch];
            end else begin
                offset[grant_ch] <= offset[grant_ch] + offset_w'(burst_len);
            end
        end
    end

endmodule

`default_nettype wire

/* design/burst_writer.sv */
`default_nettype none

module burst_writer (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic                                                     start,
    input  logic [wr_arb_pkg::ch_w-1:0]                              grant_ch,
    input  logic [wr_arb_pkg::addr_w-1:0]                            burst_addr,
    input  logic [wr_arb_pkg::num_ch-1:0][wr_arb_pkg::data_w-1:0]    ch_data,
    input  logic                                                     axi_awready,
    input  logic                                                     axi_wready,
    input  logic                                                     axi_bvalid,
    output logic                                                     done,
    output logic                                                     aw_fire,
    output logic [wr_arb_pkg::num_ch-1:0][wr_arb_pkg::rd_ptr_w-1:0]  ch_rd_addr,
    output logic [wr_arb_pkg::addr_w-1:0]                            axi_awaddr,
    output logic                                                     axi_awvalid,
    output logic [wr_arb_pkg::data_w-1:0]                            axi_wdata,
    output logic                                                     axi_wvalid,
    output logic                                                     axi_wlast,
    output logic                                                     axi_bready
);

    import wr_arb_pkg::*;

    logic [beat_w-1:0] beat;
    logic              w_fire;
    logic              last_beat;

    assign aw_fire   = axi_awvalid & axi_awready;
    assign w_fire    = axi_wvalid & axi_wready;
    assign last_beat = (beat == beat_w'(burst_len - 1));
    assign done      = axi_bready & axi_bvalid;

    // address holds until the offset moves on aw_fire
    assign axi_awaddr = burst_addr;
    assign axi_wdata  = ch_data[grant_ch]; // buffer word at its pointer
    assign axi_wlast  = axi_wvalid & last_beat;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            axi_awvalid <= 1'b0;
        end else if (start) begin
            axi_awvalid <= 1'b1;
        end else if (aw_fire) begin
            axi_awvalid <= 1'b0;
        end
    end

    // data phase of 16 transfers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            axi_wvalid <= 1'b0;
            beat       <= '0;
        end else begin
            if (aw_fire) begin
                axi_wvalid <= 1'b1;
            end else if (w_fire && last_beat) begin
                axi_wvalid <= 1'b0;
            end
            if (w_fire) begin
                beat <= beat + 1'b1; // wraps to 0 after the last beat
            end
        end
    end

    // response phase
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            axi_bready <= 1'b0;
        end else if (w_fire && last_beat) begin
            axi_bready <= 1'b1;
        end else if (axi_bvalid) begin
            axi_bready <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ch_rd_addr <= '0;
        end else if (w_fire) begin
            ch_rd_addr[grant_ch] <= ch_rd_addr[grant_ch] + 1'b1; // wraps at 32
        end
    end

endmodule

`default_nettype wire

/* design/wr_arbiter_top.sv */
`default_nettype none

module wr_arbiter_top (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic [wr_arb_pkg::num_ch-1:0]                            ch_ready,
    input  logic [wr_arb_pkg::num_ch-1:0]                            ch_frame_end,
    input  logic [wr_arb_pkg::num_ch-1:0][wr_arb_pkg::data_w-1:0]    ch_data,
    output logic [wr_arb_pkg::num_ch-1:0][wr_arb_pkg::rd_ptr_w-1:0]  ch_rd_addr,
    output logic [wr_arb_pkg::addr_w-1:0]                            axi_awaddr,
    output logic                                                     axi_awvalid,
    input  logic                                                     axi_awready,
    output logic [wr_arb_pkg::data_w-1:0]                            axi_wdata,
    output logic                                                     axi_wvalid,
    output logic                                                     axi_wlast,
    input  logic                                                     axi_wready,
    input  logic                                                     axi_bvalid,
    output logic                                                     axi_bready
);

    import wr_arb_pkg::*;

    logic              start;
    logic              done;
    logic              aw_fire;
    logic [ch_w-1:0]   grant_ch;
    logic [addr_w-1:0] burst_addr;

    channel_scheduler u_sched (
        .clk      (clk),
        .rst      (rst),
        .ch_ready (ch_ready),
        .done     (done),
        .start    (start),
        .grant_ch (grant_ch)
    );

    frame_addr_gen u_addr (
        .clk          (clk),
        .rst          (rst),
        .grant_ch     (grant_ch),
        .aw_fire      (aw_fire),
        .ch_frame_end (ch_frame_end),
        .burst_addr   (burst_addr)
    );

    burst_writer u_writer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .grant_ch    (grant_ch),
        .burst_addr  (burst_addr),
        .ch_data     (ch_data),
        .axi_awready (axi_awready),
        .axi_wready  (axi_wready),
        .axi_bvalid  (axi_bvalid),
        .done        (done),
        .aw_fire     (aw_fire),
        .ch_rd_addr  (ch_rd_addr),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_wdata   (axi_wdata),
        .axi_wvalid  (axi_wvalid),
        .axi_wlast   (axi_wlast),
        .axi_bready  (axi_bready)
    );

endmodule

`default_nettype wire

/* verification/wr_arbiter_checker.sv */
`default_nettype none

module wr_arbiter_checker (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic [wr_arb_pkg::num_ch-1:0]                            ch_frame_end,
    input  logic [wr_arb_pkg::num_ch-1:0][wr_arb_pkg::rd_ptr_w-1:0]  ch_rd_addr,
    input  logic [wr_arb_pkg::addr_w-1:0]                            axi_awaddr,
    input  logic                                                     axi_awvalid,
    input  logic                                                     axi_awready,
    input  logic [wr_arb_pkg::data_w-1:0]                            axi_wdata,
    input  logic                                                     axi_wvalid,
    input  logic                                                     axi_wlast,
    input  logic                                                     axi_wready,
    input  logic                                                     axi_bvalid,
    input  logic                                                     axi_bready,
    output int                                                       bursts_done,
    output int                                                       error_count
);

    import wr_arb_pkg::*;

    logic [ch_w-1:0]     visit_ch;   // next channel in the cyclic order
    logic [ch_w-1:0]     cur_ch;
    logic [addr_w-1:0]   cur_addr;
    logic [offset_w-1:0] offset [num_ch];
    logic                bank [num_ch];
    logic [rd_ptr_w-1:0] ptr [num_ch];
    logic                in_burst;   // address accepted, response not yet
    logic                reset_seen;
    logic                aw_waiting; // valid without ready last cycle
    logic                w_waiting;
    logic [addr_w-1:0]   last_awaddr;
    logic [data_w-1:0]   last_wdata;
    int                  beats;
    int                  checks;
    int                  tests;
    int                  tests_failed;
    int                  errs_at_start;

    // buffer contents by the same mixing rule as the buffer model
    function automatic logic [data_w-1:0] buffer_word(input int c, input int p);
        return (data_w'(c) << 28) ^ (data_w'(p) * 32'h9e37_79b1) ^ 32'h00c3_5a00;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            error_count++;
            $display("error %s: expected %h, got %h at %0t", name, expected, got, $time);
        end
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic close_test(input string name);
        tests++;
        if (error_count != errs_at_start) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic clear_model();
        int c;
        visit_ch   = '0;
        in_burst   = 1'b0;
        reset_seen = 1'b0;
        aw_waiting = 1'b0;
        w_waiting  = 1'b0;
        beats      = 0;
        for (c = 0; c < num_ch; c++) begin
            offset[c] = '0;
            bank[c]   = 1'b0;
            ptr[c]    = '0;
        end
    endtask

    task automatic check_reset_state();
        int c;
        errs_at_start = error_count;
        compare_value("axi_awvalid", axi_awvalid, 0);
        compare_value("axi_wvalid", axi_wvalid, 0);
        compare_value("axi_wlast", axi_wlast, 0);
        compare_value("axi_bready", axi_bready, 0);
        for (c = 0; c < num_ch; c++) begin
            compare_value($sformatf("ch_rd_addr[%0d]", c), ch_rd_addr[c], 0);
        end
        close_test("reset");
        reset_seen = 1'b1;
    endtask

    task automatic start_burst();
        errs_at_start = error_count;
        cur_addr = {visit_ch, bank[visit_ch], offset[visit_ch]};
        compare_value("axi_awaddr channel", axi_awaddr[addr_w-1 -: ch_w], visit_ch);
        compare_value("axi_awaddr", axi_awaddr, cur_addr);
        if (ch_frame_end[visit_ch]) begin
            offset[visit_ch] = '0; // last burst of the frame
            bank[visit_ch]   = ~bank[visit_ch];
        end else begin
            offset[visit_ch] = offset[visit_ch] + offset_w'(burst_len);
        end
        cur_ch   = visit_ch;
        in_burst = 1'b1;
        beats    = 0;
    endtask

    task automatic take_beat();
        if (!in_burst) begin
            report_problem("data beat accepted with no open burst");
        end else if (beats >= burst_len) begin
            report_problem("more than 16 data beats in one burst");
        end else begin
            compare_value("axi_wdata", axi_wdata, buffer_word(cur_ch, ptr[cur_ch]));
            compare_value("axi_wlast", axi_wlast, beats == burst_len - 1);
            ptr[cur_ch] = ptr[cur_ch] + 1'b1;
            beats++;
        end
    endtask

    task automatic end_burst();
        if (!in_burst) begin
            report_problem("write response accepted with no open burst");
        end else begin
            if (beats != burst_len) begin
                report_problem($sformatf("burst closed after %0d data beats", beats));
            end
            close_test($sformatf("burst %0d ch %0d addr %05h", bursts_done, cur_ch, cur_addr));
            bursts_done++;
            visit_ch = (visit_ch == ch_w'(num_ch - 1)) ? '0 : visit_ch + 1'b1;
            in_burst = 1'b0;
        end
    endtask

    task automatic check_cycle();
        int c;
        // pointers hold except on an accepted beat
        for (c = 0; c < num_ch; c++) begin
            compare_value($sformatf("ch_rd_addr[%0d]", c), ch_rd_addr[c], ptr[c]);
        end
        if (aw_waiting) begin
            if (!axi_awvalid) report_problem("axi_awvalid dropped before the address was taken");
            compare_value("axi_awaddr", axi_awaddr, last_awaddr);
        end
        if (w_waiting) begin
            if (!axi_wvalid) report_problem("axi_wvalid dropped before the beat was taken");
            compare_value("axi_wdata", axi_wdata, last_wdata);
        end
        if (axi_bready && in_burst && beats < burst_len) begin
            report_problem("axi_bready raised before the last data beat");
        end
        if (axi_awvalid && in_burst) begin
            report_problem("new address issued before the previous response");
        end else if (axi_awvalid && axi_awready) begin
            start_burst();
        end
        if (axi_wvalid && axi_wready) take_beat();
        if (axi_bvalid && axi_bready) end_burst();
        aw_waiting  = axi_awvalid && !axi_awready;
        w_waiting   = axi_wvalid && !axi_wready;
        last_awaddr = axi_awaddr;
        last_wdata  = axi_wdata;
    endtask

    task automatic print_counts();
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests - tests_failed, tests_failed, checks, error_count);
    endtask

    initial begin
        bursts_done  = 0;
        error_count  = 0;
        checks       = 0;
        tests        = 0;
        tests_failed = 0;
    end

    // everything is stable half a cycle after the drive point
    always @(negedge clk) begin
        if (rst !== 1'b1) begin
            clear_model();
        end else begin
            if (!reset_seen) begin
                check_reset_state();
            end
            check_cycle();
        end
    end

endmodule

`default_nettype wire

/* verification/tb_wr_arbiter.sv */
`default_nettype none

module tb_wr_arbiter;

    import wr_arb_pkg::*;

    localparam int clk_period     = 40;
    localparam int num_bursts     = 60;
    localparam int max_delay      = 3;
    localparam int timeout_cycles = num_bursts * burst_len * (max_delay + 2) * 4;

    logic                             clk;
    logic                             rst;
    logic [num_ch-1:0]                ch_ready;
    logic [num_ch-1:0]                ch_frame_end;
    logic [num_ch-1:0][data_w-1:0]    ch_data;
    logic [num_ch-1:0][rd_ptr_w-1:0]  ch_rd_addr;
    logic [addr_w-1:0]                axi_awaddr;
    logic                             axi_awvalid;
    logic                             axi_awready;
    logic [data_w-1:0]                axi_wdata;
    logic                             axi_wvalid;
    logic                             axi_wlast;
    logic                             axi_wready;
    logic                             axi_bvalid;
    logic                             axi_bready;
    logic [31:0]                      lcg_state = 32'd47688;
    logic                             aw_hs;
    logic                             w_hs;
    logic                             b_hs;
    logic [ch_w-1:0]                  burst_ch;
    int                               aw_cnt;
    int                               w_cnt;
    int                               b_cnt;
    int                               bursts_done;
    int                               error_count;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, lcg_state[31:16]}; // upper bits mix better
    endfunction

    function automatic int rand_delay();
        return int'(next_rand() % (max_delay + 1));
    endfunction

    function automatic logic [data_w-1:0] buffer_word(input int c, input int p);
        return (data_w'(c) << 28) ^ (data_w'(p) * 32'h9e37_79b1) ^ 32'h00c3_5a00;
    endfunction

    // memory slave raising each ready or valid after 0 to 3 cycles
    task automatic drive_memory();
        if (aw_hs) begin
            axi_awready = 1'b0;
            aw_cnt      = rand_delay();
        end else if (axi_awvalid && !axi_awready) begin
            if (aw_cnt == 0) axi_awready = 1'b1;
            else aw_cnt--;
        end
        if (w_hs) begin
            axi_wready = 1'b0;
            w_cnt      = rand_delay();
        end else if (axi_wvalid && !axi_wready) begin
            if (w_cnt == 0) axi_wready = 1'b1;
            else w_cnt--;
        end
        if (b_hs) begin
            axi_bvalid = 1'b0;
            b_cnt      = rand_delay();
        end else if (axi_bready && !axi_bvalid) begin
            if (b_cnt == 0) axi_bvalid = 1'b1;
            else b_cnt--;
        end
    endtask

    task automatic drive_buffers();
        int          c;
        logic [31:0] r;
        r        = next_rand();
        ch_ready = r[4:0] & r[12:8];
        for (c = 0; c < num_ch; c++) begin
            ch_data[c] = buffer_word(c, ch_rd_addr[c]);
        end
        if (b_hs) begin
            ch_frame_end[burst_ch] = (next_rand() % 4) == 0; // only once its burst is over
        end
    endtask

    wr_arbiter_top DUT (
        .clk          (clk),
        .rst          (rst),
        .ch_ready     (ch_ready),
        .ch_frame_end (ch_frame_end),
        .ch_data      (ch_data),
        .ch_rd_addr   (ch_rd_addr),
        .axi_awaddr   (axi_awaddr),
        .axi_awvalid  (axi_awvalid),
        .axi_awready  (axi_awready),
        .axi_wdata    (axi_wdata),
        .axi_wvalid   (axi_wvalid),
        .axi_wlast    (axi_wlast),
        .axi_wready   (axi_wready),
        .axi_bvalid   (axi_bvalid),
        .axi_bready   (axi_bready)
    );

    wr_arbiter_checker u_check (
        .clk          (clk),
        .rst          (rst),
        .ch_frame_end (ch_frame_end),
        .ch_rd_addr   (ch_rd_addr),
        .axi_awaddr   (axi_awaddr),
        .axi_awvalid  (axi_awvalid),
        .axi_awready  (axi_awready),
        .axi_wdata    (axi_wdata),
        .axi_wvalid   (axi_wvalid),
        .axi_wlast    (axi_wlast),
        .axi_wready   (axi_wready),
        .axi_bvalid   (axi_bvalid),
        .axi_bready   (axi_bready),
        .bursts_done  (bursts_done),
        .error_count  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        int c;
        rst         = 1'b0;
        ch_ready    = '0;
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        axi_bvalid  = 1'b0;
        aw_hs       = 1'b0;
        w_hs        = 1'b0;
        b_hs        = 1'b0;
        burst_ch    = '0;
        aw_cnt      = rand_delay();
        w_cnt       = rand_delay();
        b_cnt       = rand_delay();
        for (c = 0; c < num_ch; c++) begin
            ch_frame_end[c] = (next_rand() % 4) == 0;
            ch_data[c]      = buffer_word(c, 0);
        end
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b1;
        forever begin
            @(negedge clk);
            aw_hs = axi_awvalid && axi_awready; // transfers on the coming edge
            w_hs  = axi_wvalid && axi_wready;
            b_hs  = axi_bvalid && axi_bready;
            if (aw_hs) burst_ch = axi_awaddr[addr_w-1 -: ch_w];
            @(posedge clk);
            #5;
            drive_memory();
            drive_buffers();
        end
    end

    initial begin
        wait (rst === 1'b1);
        wait (bursts_done == num_bursts);
        @(posedge clk);
        u_check.print_counts();
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog: only %0d of %0d bursts finished in time", bursts_done, num_bursts);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* wr_arbiter_top.f */
design/wr_arb_pkg.sv
design/channel_scheduler.sv
design/frame_addr_gen.sv
design/burst_writer.sv
design/wr_arbiter_top.sv
verification/wr_arbiter_checker.sv
verification/tb_wr_arbiter.sv

/* Bender.yml */
package:
  name: wr_arbiter

sources:
  - files:
      - design/wr_arb_pkg.sv
      - design/channel_scheduler.sv
      - design/frame_addr_gen.sv
      - design/burst_writer.sv
      - design/wr_arbiter_top.sv
  - target: test
    files:
      - verification/wr_arbiter_checker.sv
      - verification/tb_wr_arbiter.sv
